// ==== hdl/secp256k1_pkg.sv ====
/*
  secp256k1 field arithmetic definitions.
  element and product widths, packed element/product types,
  operation tag type, and the prime widened for range checks.
*/
package secp256k1_pkg;

  localparam int FE_BITS   = 256;  // one field element.
  localparam int PROD_BITS = 512;  // full product width.

  typedef logic [FE_BITS-1:0]   fe_t;     // 8 x 32-bit words.
  typedef logic [PROD_BITS-1:0] prod_t;   // 16 x 32-bit words.
  typedef logic [7:0]           fp_tag_t; // software op tag.

  // p = 2^256 - 2^32 - 977, zero-extended to product width.
  localparam prod_t p_eq = {
    {FE_BITS{1'b0}},
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F
  };

endpackage

// ==== hdl/fp_bus_pkg.sv ====
/*
  Wishbone classic request/response structs
  and the byte-address register map of the multiplier.
*/
package fp_bus_pkg;

  typedef struct packed {
    logic        cyc;  // bus cycle.
    logic        stb;  // strobe.
    logic        we;   // write enable.
    logic [7:0]  adr;  // byte address.
    logic [31:0] dat;  // write data.
    logic [3:0]  sel;  // byte lanes.
  } wb_req_t;

  typedef struct packed {
    logic        ack;  // one-cycle ack.
    logic [31:0] dat;  // read data.
  } wb_rsp_t;

  localparam logic [7:0] REG_A_BASE = 8'h00; // A words 0..7, lsw first.
  localparam logic [7:0] REG_B_BASE = 8'h20; // B words 0..7.
  localparam logic [7:0] REG_CTRL   = 8'h40; // [0] start, [15:8] tag.
  localparam logic [7:0] REG_STATUS = 8'h44; // busy, done, err, tag.
  localparam logic [7:0] REG_R_BASE = 8'h80; // result words, read-only.

endpackage

// ==== hdl/fp_wb_regs.sv ====
/*
  Wishbone classic slave for the field multiplier.
  operand registers with byte lanes, start/status control,
  operand range check, result and status readback.
*/
`timescale 1ns/1ns

module fp_wb_regs (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  fp_bus_pkg::wb_req_t    i_wb,
  output fp_bus_pkg::wb_rsp_t    o_wb,
  output secp256k1_pkg::fe_t     o_a,
  output secp256k1_pkg::fe_t     o_b,
  output secp256k1_pkg::fp_tag_t o_tag,
  output logic                   o_val,
  output logic                   o_err,
  output logic                   o_start,
  input  logic                   i_rdy,
  input  logic                   i_done,
  input  secp256k1_pkg::fe_t     i_res,
  input  logic                   i_res_err,
  input  secp256k1_pkg::fp_tag_t i_res_tag
);
  import secp256k1_pkg::*;
  import fp_bus_pkg::*;

  logic        req;       // new request not yet acked.
  logic        wr;        // write part of req.
  logic [2:0]  widx;      // word index within a bank.
  logic        sel_a;
  logic        sel_b;
  logic        sel_ctrl;
  logic        sel_sts;
  logic        sel_r;
  fp_tag_t     ctl_tag;   // tag as last written to CTRL.
  logic        busy_q;
  logic        done_q;
  logic        err_q;
  fp_tag_t     tag_q;     // tag returned with the result.
  logic        sts_busy;
  logic        sts_done;
  logic        sts_err;
  fp_tag_t     sts_tag;
  logic [31:0] rd_dat;

  assign req      = i_wb.cyc & i_wb.stb & ~o_wb.ack; // ack follows one cycle later.
  assign wr       = req & i_wb.we;
  assign widx     = i_wb.adr[4:2];
  assign sel_a    = (i_wb.adr[7:5] == REG_A_BASE[7:5]);
  assign sel_b    = (i_wb.adr[7:5] == REG_B_BASE[7:5]);
  assign sel_ctrl = (i_wb.adr[7:2] == REG_CTRL[7:2]);
  assign sel_sts  = (i_wb.adr[7:2] == REG_STATUS[7:2]);
  assign sel_r    = (i_wb.adr[7:5] == REG_R_BASE[7:5]);

  // done strobe shows through in its own cycle.
  assign sts_busy = busy_q & ~i_done;
  assign sts_done = done_q | i_done;
  assign sts_err  = i_done ? i_res_err : err_q;
  assign sts_tag  = i_done ? i_res_tag : tag_q;

  always_comb begin
    rd_dat = '0; // unmapped reads as zero.
    if (sel_a) begin
      rd_dat = o_a[widx*32 +: 32];
    end else if (sel_b) begin
      rd_dat = o_b[widx*32 +: 32];
    end else if (sel_ctrl) begin
      rd_dat = {16'h0, ctl_tag, 8'h0}; // start reads back 0.
    end else if (sel_sts) begin
      rd_dat = {16'h0, sts_tag, 5'h0, sts_err, sts_done, sts_busy};
    end else if (sel_r) begin
      rd_dat = i_res[widx*32 +: 32];
    end
  end

  // byte-lane writes of operand words.
  always_ff @(posedge i_clk) begin
    for (int j = 0; j < 4; j++) begin
      if (wr && sel_a && i_wb.sel[j]) begin
        o_a[widx*32 + j*8 +: 8] <= i_wb.dat[j*8 +: 8];
      end
      if (wr && sel_b && i_wb.sel[j]) begin
        o_b[widx*32 + j*8 +: 8] <= i_wb.dat[j*8 +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb.ack <= 1'b0;
      o_wb.dat <= '0;
    end else begin
      o_wb.ack <= req; // single-cycle ack.
      if (req) begin
        o_wb.dat <= i_wb.we ? 32'h0 : rd_dat;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ctl_tag <= '0;
      o_start <= 1'b0;
      o_val   <= 1'b0;
      o_err   <= 1'b0;
      o_tag   <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
      tag_q   <= '0;
    end else begin
      if (wr && sel_ctrl && i_wb.sel[1]) begin
        ctl_tag <= i_wb.dat[15:8];
      end
      // start strobe is dropped while busy.
      o_start <= wr & sel_ctrl & i_wb.sel[0] & i_wb.dat[0] & ~busy_q;
      if (o_start) begin
        o_val  <= 1'b1;  // launch held until accepted.
        busy_q <= 1'b1;
        done_q <= 1'b0;
        o_tag  <= ctl_tag;
        o_err  <= (prod_t'(o_a) >= p_eq) | (prod_t'(o_b) >= p_eq); // operand range.
      end else if (o_val && i_rdy) begin
        o_val <= 1'b0;
      end
      if (i_done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
        err_q  <= i_res_err;
        tag_q  <= i_res_tag;
      end
    end
  end

endmodule

// ==== hdl/fp_mult_256.sv ====
/*
  Two-stage pipelined 256x256 multiplier.
  stage one: four 128x128 partial products; stage two: aligned sum.
  tag and error flag ride along with the valid bits.
*/
`timescale 1ns/1ns

module fp_mult_256 #(
  parameter type T_CTL = secp256k1_pkg::fp_tag_t
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  secp256k1_pkg::fe_t   i_a,
  input  secp256k1_pkg::fe_t   i_b,
  input  logic                 i_val,
  input  logic                 i_err,
  input  T_CTL                 i_ctl,
  output logic                 o_rdy,
  output secp256k1_pkg::prod_t o_dat,
  output logic                 o_val,
  output logic                 o_err,
  output T_CTL                 o_ctl,
  input  logic                 i_rdy
);
  import secp256k1_pkg::*;

  logic [255:0] pp_ll;  // a_lo * b_lo.
  logic [255:0] pp_lh;  // a_lo * b_hi.
  logic [255:0] pp_hl;  // a_hi * b_lo.
  logic [255:0] pp_hh;  // a_hi * b_hi.
  logic         v1;     // stage one valid.
  logic         e1;
  T_CTL         c1;
  logic         en;     // pipeline advance.

  assign en    = ~o_val | i_rdy; // move unless output is stuck.
  assign o_rdy = i_rdy;          // same rule as the reduction stage.

  always_ff @(posedge i_clk) begin
    if (en) begin
      pp_ll <= i_a[127:0]   * i_b[127:0];
      pp_lh <= i_a[127:0]   * i_b[255:128];
      pp_hl <= i_a[255:128] * i_b[127:0];
      pp_hh <= i_a[255:128] * i_b[255:128];
      c1    <= i_ctl;
      // align and sum.
      o_dat <= prod_t'(pp_ll)
             + (prod_t'(pp_lh) << 128)
             + (prod_t'(pp_hl) << 128)
             + (prod_t'(pp_hh) << 256);
      o_ctl <= c1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1    <= 1'b0;
      e1    <= 1'b0;
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (en) begin
      v1    <= i_val & o_rdy; // accepted input.
      e1    <= i_err;
      o_val <= v1;
      o_err <= e1;
    end
  end

endmodule

// ==== hdl/secp256k1_mod.sv ====
/*
  secp256k1 two-fold reduction of a 512-bit product.
  fold: H*c + L with c = 2^32 + 977, applied twice.
  err when the input flag is set or the folded value is >= p.
*/
`timescale 1ns/1ns

module secp256k1_mod #(
  parameter int  USE_MULT = 0,  // 1: multiplier form of the fold.
  parameter type T_CTL    = secp256k1_pkg::fp_tag_t
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  secp256k1_pkg::prod_t i_dat,
  input  logic                 i_val,
  input  logic                 i_err,
  input  T_CTL                 i_ctl,
  output logic                 o_rdy,
  output secp256k1_pkg::fe_t   o_dat,
  output T_CTL                 o_ctl,
  output logic                 o_val,
  output logic                 o_err,
  input  logic                 i_rdy
);
  import secp256k1_pkg::*;

  // c = 2^32 + 2^9 + 2^8 + 2^7 + 2^6 + 2^4 + 1.
  localparam prod_t FOLD_C = prod_t'(33'h1_0000_03D1);

  prod_t      res0;    // after fold one.
  prod_t      res1;    // after fold two.
  logic [1:0] val;
  logic [1:0] err;
  T_CTL       ctl [2];
  logic       en;

  // one fold: high half times c plus low half.
  function automatic prod_t fold(input prod_t x);
    prod_t h;
    prod_t l;
    h = prod_t'(x[PROD_BITS-1:FE_BITS]);
    l = prod_t'(x[FE_BITS-1:0]);
    if (USE_MULT == 1) begin
      return h * FOLD_C + l; // dsp friendly.
    end
    return (h << 32) + (h << 9) + (h << 8) + (h << 7) + (h << 6) + (h << 4) + h + l;
  endfunction

  assign en    = ~o_val | i_rdy;
  assign o_rdy = i_rdy;  // ready forwarded combinationally.

  always_ff @(posedge i_clk) begin
    if (en) begin
      res0   <= fold(i_dat);
      res1   <= fold(res0);
      ctl[0] <= i_ctl;
      ctl[1] <= ctl[0];
      o_ctl  <= ctl[1];
      o_dat  <= res1[FE_BITS-1:0]; // low 256 bits only.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val   <= '0;
      err   <= '0;
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (en) begin
      val   <= {val[0], i_val & o_rdy};
      err   <= {err[0], i_err};
      o_val <= val[1];
      o_err <= err[1] | (res1 >= p_eq); // not fully reduced.
    end
  end

endmodule

// ==== hdl/fp_result_hold.sv ====
/*
  One-entry result holder at the end of the pipeline.
  keeps result, err and tag for readback and pulses done.
*/
`timescale 1ns/1ns

module fp_result_hold (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  secp256k1_pkg::fe_t     i_dat,
  input  logic                   i_val,
  input  logic                   i_err,
  input  secp256k1_pkg::fp_tag_t i_ctl,
  input  logic                   i_clear,
  output logic                   o_rdy,
  output logic                   o_done,
  output secp256k1_pkg::fe_t     o_res,
  output logic                   o_res_err,
  output secp256k1_pkg::fp_tag_t o_res_tag
);
  import secp256k1_pkg::*;

  logic full;  // holding an unread op.

  assign o_rdy = ~full; // no overwrite of a held result.

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full      <= 1'b0;
      o_done    <= 1'b0;
      o_res     <= '0;   // result words read 0 after reset.
      o_res_err <= 1'b0;
      o_res_tag <= '0;
    end else begin
      o_done <= 1'b0;
      if (i_clear) begin
        full <= 1'b0;    // new start, data kept until replaced.
      end else if (i_val && !full) begin
        full      <= 1'b1;
        o_done    <= 1'b1; // single-cycle strobe.
        o_res     <= i_dat;
        o_res_err <= i_err;
        o_res_tag <= i_ctl;
      end
    end
  end

endmodule

// ==== hdl/fp_mul_top.sv ====
/*
  secp256k1 field multiplier top level.
  bus registers, multiplier, reduction and result holder.
*/
`timescale 1ns/1ns

module fp_mul_top #(
  parameter int USE_MULT = 0
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  fp_bus_pkg::wb_req_t i_wb,
  output fp_bus_pkg::wb_rsp_t o_wb
);
  import secp256k1_pkg::*;

  fe_t     op_a;
  fe_t     op_b;
  fp_tag_t op_tag;
  logic    op_val;
  logic    op_err;
  logic    start;
  logic    mul_rdy;
  prod_t   mul_dat;
  logic    mul_val;
  logic    mul_err;
  fp_tag_t mul_tag;
  logic    red_rdy;
  fe_t     red_dat;
  logic    red_val;
  logic    red_err;
  fp_tag_t red_tag;
  logic    hold_rdy;
  logic    done;
  fe_t     res;
  logic    res_err;
  fp_tag_t res_tag;

  fp_wb_regs u_regs (
    .i_clk(i_clk), .i_rst(i_rst), .i_wb(i_wb), .o_wb(o_wb),
    .o_a(op_a), .o_b(op_b), .o_tag(op_tag), .o_val(op_val), .o_err(op_err),
    .o_start(start), .i_rdy(mul_rdy), .i_done(done), .i_res(res),
    .i_res_err(res_err), .i_res_tag(res_tag)
  );

  fp_mult_256 #(.T_CTL(fp_tag_t)) u_mult (
    .i_clk(i_clk), .i_rst(i_rst), .i_a(op_a), .i_b(op_b), .i_val(op_val),
    .i_err(op_err), .i_ctl(op_tag), .o_rdy(mul_rdy), .o_dat(mul_dat),
    .o_val(mul_val), .o_err(mul_err), .o_ctl(mul_tag), .i_rdy(red_rdy)
  );

  secp256k1_mod #(.USE_MULT(USE_MULT), .T_CTL(fp_tag_t)) u_mod (
    .i_clk(i_clk), .i_rst(i_rst), .i_dat(mul_dat), .i_val(mul_val),
    .i_err(mul_err), .i_ctl(mul_tag), .o_rdy(red_rdy), .o_dat(red_dat),
    .o_ctl(red_tag), .o_val(red_val), .o_err(red_err), .i_rdy(hold_rdy)
  );

  fp_result_hold u_hold (
    .i_clk(i_clk), .i_rst(i_rst), .i_dat(red_dat), .i_val(red_val),
    .i_err(red_err), .i_ctl(red_tag), .i_clear(start), .o_rdy(hold_rdy),
    .o_done(done), .o_res(res), .o_res_err(res_err), .o_res_tag(res_tag)
  );

endmodule

// ==== verif/tb_fp_model.svh ====
/*
  reference model for the field multiplier testbench.
  prime and fold constant, full product, fold step, two folds,
  expected err flag, residue mod p and operand reduction below p.
*/
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// p = 2^256 - 2^32 - 2^9 - 2^8 - 2^7 - 2^6 - 2^4 - 1.
localparam logic [511:0] P_FIELD = (512'd1 << 256) - (512'd1 << 32) - (512'd1 << 9)
  - (512'd1 << 8) - (512'd1 << 7) - (512'd1 << 6) - (512'd1 << 4) - 512'd1;

// 2^256 mod p, the fold multiplier.
localparam logic [511:0] C_FOLD = (512'd1 << 32) + (512'd1 << 9) + (512'd1 << 8)
  + (512'd1 << 7) + (512'd1 << 6) + (512'd1 << 4) + 512'd1;

function automatic logic [511:0] mul_full(input logic [255:0] a, input logic [255:0] b);
  logic [511:0] wide_a;
  logic [511:0] wide_b;
  wide_a = {256'h0, a};
  wide_b = {256'h0, b};
  return wide_a * wide_b; // exact 512-bit product.
endfunction

function automatic logic [511:0] fold_step(input logic [511:0] x);
  logic [511:0] hi;
  logic [511:0] lo;
  hi = {256'h0, x[511:256]};
  lo = {256'h0, x[255:0]};
  return hi * C_FOLD + lo; // H*c + L.
endfunction

function automatic logic [511:0] fold_twice(input logic [511:0] x);
  return fold_step(fold_step(x));
endfunction

// err when F is not below p or an operand is out of range.
function automatic logic expect_err(input logic [255:0] a, input logic [255:0] b,
                                    input logic [511:0] f);
  return (f >= P_FIELD) || ({256'h0, a} >= P_FIELD) || ({256'h0, b} >= P_FIELD);
endfunction

function automatic logic [255:0] mod_p(input logic [511:0] x);
  logic [511:0] r;
  r = x % P_FIELD; // plain division, independent of folding.
  return r[255:0];
endfunction

function automatic logic [255:0] below_p(input logic [255:0] v);
  logic [511:0] w;
  w = {256'h0, v};
  if (w >= P_FIELD) begin
    w = w - P_FIELD; // one subtraction suffices below 2^256.
  end
  return w[255:0];
endfunction

`endif

// ==== verif/tb_fp_mul.sv ====
/*
  testbench for the secp256k1 field multiplier.
  clock, reset, Wishbone access tasks, LFSR operands,
  directed, random, range, busy and status tests.
*/
`timescale 1ns/1ns

module tb_fp_mul;
  import secp256k1_pkg::*;
  import fp_bus_pkg::*;

  `include "tb_fp_model.svh"

  localparam int ACK_LIMIT  = 16;  // cycles per bus access.
  localparam int DONE_LIMIT = 40;  // status polls per operation.

  logic        i_clk;
  logic        i_rst;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;
  bit          aborted;       // set on a timeout to skip later steps.

  fp_mul_top #(.USE_MULT(0)) i_dut (.i_clk(i_clk), .i_rst(i_rst), .i_wb(wb_req), .o_wb(wb_rsp));

  always #4 i_clk = ~i_clk; // 8 ns period.

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois form with taps 32 22 2 1.
  endfunction

  task automatic rand_fe(output fe_t v);
    for (int i = 0; i < 256; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];  // one step per bit.
    end
  endtask

  task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (aborted) return;
    assert (got === exp) else begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdat);
    int n;
    rdat = '0;
    if (aborted) return;
    @(negedge i_clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    n = 0;
    do begin
      @(negedge i_clk); // ack sampled mid-cycle.
      n++;
    end while (!wb_rsp.ack && n < ACK_LIMIT);
    rdat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;  // idle cycle before the next transfer.
    if (!wb_rsp.ack) begin
      $display("bus access to address %h was never acknowledged", adr);
      errors++;
      aborted = 1;
    end
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'h0, 4'hF, dat);
  endtask

  task automatic write_fe(input logic [7:0] base, input fe_t v);
    for (int i = 0; i < 8; i++) begin
      wb_write(base + 8'(4 * i), v[i*32 +: 32], 4'hF); // lsw first.
    end
  endtask

  task automatic read_fe(input logic [7:0] base, output fe_t v);
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      wb_read(base + 8'(4 * i), w);
      v[i*32 +: 32] = w;
    end
  endtask

  task automatic start_op(input fp_tag_t tag);
    wb_write(REG_CTRL, {16'h0, tag, 8'h01}, 4'h3); // start bit and tag.
  endtask

  task automatic wait_done(output logic [31:0] sts);
    int n;
    n = 0;
    sts = '0;
    while (!sts[1] && n < DONE_LIMIT && !aborted) begin
      wb_read(REG_STATUS, sts);
      n++;
    end
    if (!sts[1] && !aborted) begin
      $display("operation did not finish within %0d status polls", DONE_LIMIT);
      errors++;
      aborted = 1;
    end
  endtask

  task automatic run_op(input fe_t a, input fe_t b, input fp_tag_t tag,
                        output fe_t res, output logic [31:0] sts);
    write_fe(REG_A_BASE, a);
    write_fe(REG_B_BASE, b);
    start_op(tag);
    wait_done(sts);
    read_fe(REG_R_BASE, res);
  endtask

  task automatic check_op(input fe_t a, input fe_t b, input fp_tag_t tag,
                          input fe_t res, input logic [31:0] sts);
    logic [511:0] x;
    logic [511:0] f;
    logic         e;
    x = mul_full(a, b);
    f = fold_twice(x);
    e = expect_err(a, b, f);
    check_eq("result", res, f[255:0]);  // low 256 bits of F.
    check_eq("status.err", 256'(sts[2]), 256'(e));
    check_eq("status.tag", 256'(sts[15:8]), 256'(tag));
    check_eq("status.busy", 256'(sts[0]), 256'(1'b0));
    check_eq("status.done", 256'(sts[1]), 256'(1'b1));
    if (!e) begin
      check_eq("result mod p", res, mod_p(x));
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic reset_readback();
    int          e0;
    logic [31:0] w;
    fe_t         a;
    fe_t         b;
    fe_t         r;
    e0 = errors;
    wb_read(REG_STATUS, w);
    check_eq("status after reset", 256'(w), 256'(0));
    read_fe(REG_R_BASE, r);
    check_eq("result after reset", r, '0);
    rand_fe(a);
    rand_fe(b);
    write_fe(REG_A_BASE, a);
    write_fe(REG_B_BASE, b);
    read_fe(REG_A_BASE, r);
    check_eq("a readback", r, a);
    read_fe(REG_B_BASE, r);
    check_eq("b readback", r, b);
    wb_write(REG_B_BASE + 8'hC, 32'hA1B2_C3D4, 4'b0101);  // lanes 0 and 2 only.
    b[96 +: 32] = {b[120 +: 8], 8'hB2, b[104 +: 8], 8'hD4};
    wb_read(REG_B_BASE + 8'hC, w);
    check_eq("b word 3 lanes", 256'(w), 256'(b[96 +: 32]));
    wb_write(REG_A_BASE, 32'h5E00_0000, 4'b1000);         // top lane only.
    a[31:24] = 8'h5E;
    read_fe(REG_A_BASE, r);
    check_eq("a lane 3", r, a);
    wb_read(8'h60, w);
    check_eq("unmapped read", 256'(w), 256'(0));
    end_test("reset and register readback", e0);
  endtask

  task automatic directed_products();
    int          e0;
    fe_t         gx;
    fe_t         pm1;
    fe_t         r;
    logic [31:0] sts;
    e0 = errors;
    gx  = 256'h79BE667E_F9DCBBAC_55A06295_CE870B07_029BFCDB_2DCE28D9_59F2815B_16F81798;
    pm1 = P_FIELD[255:0] - 256'd1;
    run_op('0, gx, 8'h11, r, sts);
    check_op('0, gx, 8'h11, r, sts);
    check_eq("0*x", r, '0);
    run_op(256'd1, gx, 8'h12, r, sts);
    check_op(256'd1, gx, 8'h12, r, sts);
    check_eq("1*x", r, gx);
    // (p-1)^2 folds to p+1 and is flagged by the fold rule.
    run_op(pm1, pm1, 8'h13, r, sts);
    check_op(pm1, pm1, 8'h13, r, sts);
    run_op(256'd1 << 255, 256'd2, 8'h14, r, sts);
    check_op(256'd1 << 255, 256'd2, 8'h14, r, sts);
    check_eq("2^255*2", r, C_FOLD[255:0]);  // 2^256 mod p.
    end_test("directed products", e0);
  endtask

  task automatic random_products();
    int          e0;
    fe_t         a;
    fe_t         b;
    fe_t         r;
    logic [31:0] sts;
    e0 = errors;
    for (int i = 0; i < 30; i++) begin
      rand_fe(a);
      rand_fe(b);
      a = below_p(a);
      b = below_p(b);
      run_op(a, b, 8'(8'h20 + i), r, sts);
      check_op(a, b, 8'(8'h20 + i), r, sts);
    end
    end_test("random products", e0);
  endtask

  task automatic operand_range();
    int          e0;
    fe_t         a;
    fe_t         b;
    fe_t         r;
    logic [31:0] sts;
    e0 = errors;
    a = P_FIELD[255:0] + 256'd5;  // a above p.
    rand_fe(b);
    b = below_p(b);
    run_op(a, b, 8'h31, r, sts);
    check_op(a, b, 8'h31, r, sts);
    check_eq("err with a >= p", 256'(sts[2]), 256'(1'b1));
    rand_fe(a);
    a = below_p(a);
    b = '1;                       // b above p.
    run_op(a, b, 8'h32, r, sts);
    check_op(a, b, 8'h32, r, sts);
    check_eq("err with b >= p", 256'(sts[2]), 256'(1'b1));
    end_test("operand range", e0);
  endtask

  task automatic busy_start();
    int          e0;
    fe_t         a;
    fe_t         b;
    fe_t         r;
    logic [31:0] sts;
    e0 = errors;
    rand_fe(a);
    rand_fe(b);
    a = below_p(a);
    b = below_p(b);
    write_fe(REG_A_BASE, a);
    write_fe(REG_B_BASE, b);
    start_op(8'h5A);
    start_op(8'hA5);  // lands while busy.
    wait_done(sts);
    read_fe(REG_R_BASE, r);
    check_op(a, b, 8'h5A, r, sts);
    // an accepted second start would leave a stale op behind.
    rand_fe(a);
    rand_fe(b);
    a = below_p(a);
    b = below_p(b);
    run_op(a, b, 8'h5B, r, sts);
    check_op(a, b, 8'h5B, r, sts);
    end_test("start while busy", e0);
  endtask

  task automatic status_hold();
    int          e0;
    fe_t         a;
    fe_t         b;
    fe_t         r;
    fe_t         r2;
    logic [31:0] w;
    logic [31:0] sts;
    e0 = errors;
    rand_fe(a);
    rand_fe(b);
    a = below_p(a);
    b = below_p(b);
    write_fe(REG_A_BASE, a);
    write_fe(REG_B_BASE, b);
    start_op(8'h66);
    wb_read(REG_STATUS, w);  // early poll.
    check_eq("early busy", 256'(w[0]), 256'(1'b1));
    check_eq("early done", 256'(w[1]), 256'(1'b0));
    wait_done(sts);
    read_fe(REG_R_BASE, r);
    check_op(a, b, 8'h66, r, sts);
    read_fe(REG_R_BASE, r2);
    check_eq("result reread", r2, r);
    wb_read(REG_STATUS, w);
    check_eq("status reread", 256'(w), 256'(sts));
    end_test("status and result hold", e0);
  endtask

  initial begin
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    wb_req       = '0;
    lfsr         = 32'h5379_cb7c;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    reset_readback();
    directed_products();
    random_products();
    operand_range();
    busy_start();
    status_hold();
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verif
hdl/secp256k1_pkg.sv
hdl/fp_bus_pkg.sv
hdl/fp_wb_regs.sv
hdl/fp_mult_256.sv
hdl/secp256k1_mod.sv
hdl/fp_result_hold.sv
hdl/fp_mul_top.sv
verif/tb_fp_mul.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the field multiplier testbench with Verilator, runs it,
# and decides the result from the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ns \
  -f flist.f --top-module tb_fp_mul
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_fp_mul > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
  echo "simulation reported errors"
  exit 1
fi

echo "simulation clean"
exit 0
